// File: all.f
rtl/ecc_pkg.sv
rtl/ecc_encoder.sv
rtl/ecc_syndrome_gen.sv
rtl/ecc_correct_lane.sv
rtl/ecc_result_reg.sv
rtl/ecc_96_top.sv
testbench/ecc_96_assert.sv
testbench/ecc_96_tb.sv

// File: rtl/ecc_96_top.sv
`timescale 1ns/10ps

module ecc_96_top
    import ecc_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    input  ecc_data_t    wr_data,
    output ecc_check_t   wr_parity,

    input  logic         rd_valid,
    input  ecc_rd_req_t  rd_req,
    output logic         out_valid,
    output ecc_rd_resp_t rd_resp
);

    ecc_check_t                          syndrome;
    logic                                syndrome_zero;
    logic                                check_only;
    ecc_lane_data_t [ECC_LANE_COUNT-1:0] lane_data;
    logic           [ECC_LANE_COUNT-1:0] lane_hit;

    // Write side check bits
    ecc_encoder u_wr_encoder (
        .data   (wr_data),
        .parity (wr_parity)
    );

    ecc_syndrome_gen u_syndrome_gen (
        .req           (rd_req),
        .syndrome      (syndrome),
        .syndrome_zero (syndrome_zero),
        .check_only    (check_only)
    );

    genvar g;
    generate
        for (g = 0; g < ECC_LANE_COUNT; g++) begin : g_lane
            ecc_correct_lane #(
                .LANE_INDEX (g)
            ) u_lane (
                .slice     (rd_req.data[g*ECC_LANE_W +: ECC_LANE_W]),
                .syndrome  (syndrome),
                .corrected (lane_data[g]),
                .hit       (lane_hit[g])
            );
        end
    endgenerate

    // Only clocked stage, cuts the syndrome to correction path
    ecc_result_reg u_result_reg (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_valid      (rd_valid),
        .req           (rd_req),
        .lane_data     (lane_data),
        .lane_hit      (lane_hit),
        .syndrome_zero (syndrome_zero),
        .check_only    (check_only),
        .out_valid     (out_valid),
        .resp          (rd_resp)
    );

endmodule

// File: rtl/ecc_correct_lane.sv
`timescale 1ns/10ps

module ecc_correct_lane
    import ecc_pkg::*;
#(
    parameter int LANE_INDEX = 0
)
(
    input  ecc_lane_data_t slice,
    input  ecc_check_t     syndrome,
    output ecc_lane_data_t corrected,
    output logic           hit
);

    localparam int BASE = LANE_INDEX * ECC_LANE_W;  // First data bit of this lane

    ecc_lane_data_t match;

    genvar j;
    generate
        for (j = 0; j < ECC_LANE_W; j++) begin : g_bit
            localparam ecc_check_t COL = ecc_column(BASE + j);

            assign match[j] = (syndrome == COL);
        end
    endgenerate

    // Columns are distinct, so at most one bit flips
    assign corrected = slice ^ match;
    assign hit       = |match;

endmodule

// File: rtl/ecc_encoder.sv
`timescale 1ns/10ps

module ecc_encoder
    import ecc_pkg::*;
(
    input  ecc_data_t  data,
    output ecc_check_t parity
);

    // Data bits that feed check bit k
    function automatic ecc_data_t check_mask(input int k);
        ecc_data_t  mask;
        ecc_check_t col;
        mask = '0;
        for (int i = 0; i < ECC_DATA_W; i++) begin
            col     = ecc_column(i);
            mask[i] = col[k];
        end
        return mask;
    endfunction

    genvar k;
    generate
        for (k = 0; k < ECC_CHECK_W; k++) begin : g_check
            localparam ecc_data_t MASK = check_mask(k);

            assign parity[k] = ^(data & MASK);  // Parity of selected bits
        end
    endgenerate

endmodule

// File: rtl/ecc_pkg.sv
package ecc_pkg;

    // Word geometry
    localparam int ECC_DATA_W     = 96;
    localparam int ECC_CHECK_W    = 8;
    localparam int ECC_LANE_COUNT = 4;
    localparam int ECC_LANE_W     = ECC_DATA_W / ECC_LANE_COUNT;

    // Hamming position field inside a column, overall parity sits above it
    localparam int ECC_POS_W      = ECC_CHECK_W - 1;
    localparam int ECC_POS_FIRST  = 3;   // Positions 1 and 2 belong to check bits
    localparam int ECC_POS_LIMIT  = 1 << ECC_POS_W;

    typedef logic [ECC_DATA_W-1:0]  ecc_data_t;
    typedef logic [ECC_CHECK_W-1:0] ecc_check_t;
    typedef logic [ECC_LANE_W-1:0]  ecc_lane_data_t;

    typedef logic [ECC_POS_W-1:0]   ecc_pos_t;

    typedef struct packed {
        ecc_data_t  data;
        ecc_check_t parity;
        logic       bypass;  // Pass data through untouched
    } ecc_rd_req_t;

    typedef struct packed {
        ecc_data_t data;
        logic      sbit_err;  // Corrected or check-bit-only error
        logic      dbit_err;  // Uncorrectable
    } ecc_rd_resp_t;

    // True for a power of two, those positions are taken by check bits
    function automatic logic ecc_is_pow2(input int unsigned value);
        return (value != 0) && ((value & (value - 1)) == 0);
    endfunction

    // Hamming position of data bit i
    function automatic ecc_pos_t ecc_position(input int unsigned i);
        ecc_pos_t    pos;
        int unsigned count;
        pos   = '0;
        count = 0;
        for (int unsigned p = ECC_POS_FIRST; p < ECC_POS_LIMIT; p++) begin
            if (!ecc_is_pow2(p)) begin
                if (count == i) begin
                    pos = ecc_pos_t'(p);
                end
                count++;
            end
        end
        return pos;
    endfunction

    // Column of data bit i in the check matrix
    // Top bit evens out the weight so every column is odd
    function automatic ecc_check_t ecc_column(input int unsigned i);
        ecc_pos_t pos;
        pos = ecc_position(i);
        return {~^pos, pos};
    endfunction

endpackage

// File: rtl/ecc_result_reg.sv
`timescale 1ns/10ps

module ecc_result_reg
    import ecc_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  rd_valid,
    input  ecc_rd_req_t                           req,
    input  ecc_lane_data_t [ECC_LANE_COUNT-1:0]   lane_data,
    input  logic           [ECC_LANE_COUNT-1:0]   lane_hit,
    input  logic                                  syndrome_zero,
    input  logic                                  check_only,
    output logic                                  out_valid,
    output ecc_rd_resp_t                          resp
);

    ecc_data_t    joined;
    logic         single_err;
    logic         double_err;
    ecc_rd_resp_t next_resp;

    assign joined = ecc_data_t'(lane_data);  // Lane 0 in the low bits

    // Data bit match or lone check bit
    assign single_err = (|lane_hit) || check_only;

    // Nonzero syndrome that no single flip explains
    assign double_err = !syndrome_zero && !single_err;

    always_comb begin
        if (req.bypass) begin
            next_resp.data     = req.data;
            next_resp.sbit_err = 1'b0;
            next_resp.dbit_err = 1'b0;
        end else begin
            next_resp.data     = joined;
            next_resp.sbit_err = single_err;
            next_resp.dbit_err = double_err;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            resp      <= '0;
        end else begin
            out_valid <= rd_valid;
            if (rd_valid) begin
                resp <= next_resp;  // Hold last result otherwise
            end
        end
    end

endmodule

// File: rtl/ecc_syndrome_gen.sv
`timescale 1ns/10ps

module ecc_syndrome_gen
    import ecc_pkg::*;
(
    input  ecc_rd_req_t req,
    output ecc_check_t  syndrome,
    output logic        syndrome_zero,
    output logic        check_only
);

    ecc_check_t recomputed;
    logic       single_bit;

    // Same generator as the write side
    ecc_encoder u_encoder (
        .data   (req.data),
        .parity (recomputed)
    );

    assign syndrome = recomputed ^ req.parity;

    assign syndrome_zero = (syndrome == '0);

    // At most one bit set, clearing the lowest one leaves nothing
    assign single_bit = ((syndrome & (syndrome - 1'b1)) == '0);

    // Only a stored check bit flipped, data is clean
    assign check_only = single_bit && !syndrome_zero;

endmodule

// File: testbench/ecc_96_assert.sv
`timescale 1ns/10ps

module ecc_96_assert
    import ecc_pkg::*;
(
    input logic         clk,
    input logic         rst_n,
    input ecc_data_t    wr_data,
    input ecc_check_t   wr_parity,
    input logic         rd_valid,
    input ecc_rd_req_t  rd_req,
    input logic         out_valid,
    input ecc_rd_resp_t rd_resp
);

    int           fail_count = 0;  // Read by the testbench
    ecc_check_t   ref_parity;
    ecc_check_t   ref_syndrome;
    ecc_rd_resp_t ref_resp;
    logic         ref_found;

    // Walk positions from 3 upward, skipping powers of two
    function automatic ecc_check_t ref_column(input int bit_index);
        int pos;
        int seen;
        pos  = 2;
        seen = -1;
        while (seen < bit_index) begin
            pos++;
            if ($countones(pos) != 1) begin
                seen++;
            end
        end
        return {($countones(pos) % 2 == 0), pos[6:0]};
    endfunction

    function automatic ecc_check_t ref_check(input ecc_data_t data);
        ecc_check_t acc;
        acc = '0;
        for (int i = 0; i < ECC_DATA_W; i++) begin
            if (data[i]) begin
                acc ^= ref_column(i);
            end
        end
        return acc;
    endfunction

    always_comb ref_parity = ref_check(wr_data);

    always_comb begin
        ref_syndrome      = ref_check(rd_req.data) ^ rd_req.parity;
        ref_resp.data     = rd_req.data;
        ref_resp.sbit_err = 1'b0;
        ref_resp.dbit_err = 1'b0;
        ref_found         = 1'b0;
        if (!rd_req.bypass && ref_syndrome != '0) begin
            for (int i = 0; i < ECC_DATA_W; i++) begin
                if (ref_column(i) == ref_syndrome) begin
                    ref_resp.data[i] = ~ref_resp.data[i];
                    ref_found        = 1'b1;
                end
            end
            if (ref_found || $countones(ref_syndrome) == 1) begin
                ref_resp.sbit_err = 1'b1;
            end else begin
                ref_resp.dbit_err = 1'b1;
            end
        end
    end

    a_encode: assert property (@(posedge clk) disable iff (!rst_n)
        wr_parity == ref_parity)
        else begin
            fail_count++;
            $error("MISMATCH encode: expected %h, actual %h",
                   $sampled(ref_parity), $sampled(wr_parity));
        end

    a_valid: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(rd_valid))
        else begin
            fail_count++;
            $error("out_valid does not follow rd_valid by one cycle");
        end

    a_resp: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid |=> rd_resp == $past(ref_resp))
        else begin
            fail_count++;
            $error("MISMATCH read: expected %h, actual %h",
                   $past(ref_resp), $sampled(rd_resp));
        end

    // Idle cycles keep the last response
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !rd_valid |=> rd_resp == $past(rd_resp))
        else begin
            fail_count++;
            $error("rd_resp changed while rd_valid was low");
        end

    a_reset: assert property (@(posedge clk)
        (!rst_n && $past(!rst_n)) |-> (!out_valid && rd_resp == '0))
        else begin
            fail_count++;
            $error("outputs not cleared while reset is held");
        end

endmodule

bind ecc_96_top ecc_96_assert u_check (.*);

// File: testbench/ecc_96_tb.sv
`timescale 1ns/10ps

module ecc_96_tb
    import ecc_pkg::*;
();

    localparam int CLK_PERIOD    = 8;
    localparam int DRIVE_DELAY   = 1;
    localparam int RESET_CYCLES  = 10;
    localparam int N_ENCODE      = 64;
    localparam int N_CLEAN       = 64;
    localparam int N_DOUBLE      = 64;
    localparam int N_BYPASS      = 16;
    localparam int TEST_OVERHEAD = 6;   // Drain and margin per test
    localparam int TOTAL_CYCLES  = RESET_CYCLES + N_ENCODE + N_CLEAN + ECC_DATA_W
                                 + ECC_CHECK_W + N_DOUBLE + 3 * N_BYPASS
                                 + 7 * TEST_OVERHEAD;

    logic         clk;
    logic         rst_n;
    ecc_data_t    wr_data;
    ecc_check_t   wr_parity;
    logic         rd_valid;
    ecc_rd_req_t  rd_req;
    logic         out_valid;
    ecc_rd_resp_t rd_resp;

    string test_name;
    int    tests_run;
    int    tests_failed;
    int    tb_errors;
    int    mark;

    ecc_96_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_data   (wr_data),
        .wr_parity (wr_parity),
        .rd_valid  (rd_valid),
        .rd_req    (rd_req),
        .out_valid (out_valid),
        .rd_resp   (rd_resp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Check bits of a stimulus word
    function automatic ecc_check_t hamming_check(input ecc_data_t data);
        ecc_check_t acc;
        logic [6:0] pos;
        int         p;
        acc = '0;
        p   = 3;
        for (int i = 0; i < ECC_DATA_W; i++) begin
            while ((p & (p - 1)) == 0) p++;
            pos = p[6:0];
            if (data[i]) begin
                acc ^= {~^pos, pos};
            end
            p++;
        end
        return acc;
    endfunction

    function automatic ecc_data_t random_word();
        return {$urandom, $urandom, $urandom};
    endfunction

    function automatic int failures();
        return DUT.u_check.fail_count + tb_errors;
    endfunction

    task automatic compare(input string what, input logic [127:0] expected,
                           input logic [127:0] actual);
        if (expected !== actual) begin
            tb_errors++;
            $display("MISMATCH %s %s: expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic drive_read(input ecc_data_t data, input ecc_check_t parity,
                              input logic bypass);
        @(posedge clk);
        #DRIVE_DELAY;
        rd_valid      = 1'b1;
        rd_req.data   = data;
        rd_req.parity = parity;
        rd_req.bypass = bypass;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        mark      = failures();
    endtask

    // Lets the last response reach its assertion before counting
    task automatic end_test();
        int delta;
        @(posedge clk);
        #DRIVE_DELAY;
        rd_valid = 1'b0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        delta = failures() - mark;
        tests_run++;
        if (delta != 0) begin
            tests_failed++;
        end
        $display("%-14s %s (%0d errors)", test_name, (delta == 0) ? "pass" : "FAIL", delta);
    endtask

    initial begin
        #(TOTAL_CYCLES * 2 * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, run did not finish", TOTAL_CYCLES * 2);
        $display("test failed");
        $finish;
    end

    initial begin
        ecc_data_t        word;
        ecc_check_t       par;
        logic [103:0]     code;
        int               r1;
        int               r2;
        void'($urandom(32'h5d21_dec1));
        rst_n        = 1'b0;
        wr_data      = '0;
        rd_valid     = 1'b0;
        rd_req       = '0;
        tests_run    = 0;
        tests_failed = 0;
        tb_errors    = 0;

        begin_test("reset_state");
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        @(negedge clk);
        compare("out_valid", 1'b0, out_valid);
        compare("rd_resp", '0, rd_resp);
        end_test();

        begin_test("encode");
        for (int n = 0; n < N_ENCODE; n++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            wr_data = random_word();
        end
        end_test();

        begin_test("clean_read");
        for (int n = 0; n < N_CLEAN; n++) begin
            word = random_word();
            drive_read(word, hamming_check(word), 1'b0);
        end
        end_test();

        // Sweep of every position reaches all four lanes
        begin_test("single_data");
        for (int i = 0; i < ECC_DATA_W; i++) begin
            word = random_word();
            par  = hamming_check(word);
            word[i] = ~word[i];
            drive_read(word, par, 1'b0);
        end
        end_test();

        begin_test("single_check");
        for (int k = 0; k < ECC_CHECK_W; k++) begin
            word = random_word();
            par  = hamming_check(word);
            par[k] = ~par[k];
            drive_read(word, par, 1'b0);
        end
        end_test();

        begin_test("double_error");
        for (int n = 0; n < N_DOUBLE; n++) begin
            word = random_word();
            code = {hamming_check(word), word};
            r1   = $urandom_range(103, 0);
            r2   = (r1 + $urandom_range(103, 1)) % 104;  // Never equal to r1
            code[r1] = ~code[r1];
            code[r2] = ~code[r2];
            drive_read(code[95:0], code[103:96], 1'b0);
        end
        end_test();

        begin_test("bypass_valid");
        for (int n = 0; n < N_BYPASS; n++) begin
            word = random_word();
            code = {hamming_check(word), word};
            code[$urandom_range(103, 0)] ^= 1'b1;
            code[$urandom_range(103, 0)] ^= 1'b1;
            drive_read(code[95:0], code[103:96], 1'b1);
            @(posedge clk);
            #DRIVE_DELAY;
            rd_valid = 1'b0;
            @(negedge clk);
            compare("out_valid", 1'b1, out_valid);
            compare("rd_resp", {code[95:0], 2'b00}, rd_resp);
            @(negedge clk);
            compare("out_valid", 1'b0, out_valid);
            compare("rd_resp held", {code[95:0], 2'b00}, rd_resp);
        end
        end_test();

        $display("Summary: %0d tests, %0d failed, %0d assertion failures, %0d sampled errors",
                 tests_run, tests_failed, DUT.u_check.fail_count, tb_errors);
        if (tests_failed == 0 && failures() == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
